// ==== core_pkg.sv ====
package core_pkg;

  localparam int WORD_WIDTH = 32;
  localparam int PC_WIDTH = 8;
  localparam int IMM_WIDTH = 7;

  localparam int DSTACK_DEPTH = 16;
  localparam int CSTACK_DEPTH = 8;
  localparam int LSTACK_DEPTH = 4;

  // Index 0 is data stack overflow, index 1 is underflow
  localparam int FAULT_COUNT = 2;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [PC_WIDTH-1:0] pc_t;
  typedef logic [7:0] instr_t;

  // Any opcode with bit 7 set pushes its low bits, so named opcodes stay below 8'h80
  localparam instr_t OP_ADD = 8'h01;
  localparam instr_t OP_ADDC = 8'h02;
  localparam instr_t OP_SUB = 8'h03;
  localparam instr_t OP_AND = 8'h04;
  localparam instr_t OP_OR = 8'h05;
  localparam instr_t OP_XOR = 8'h06;
  localparam instr_t OP_DUP = 8'h10;
  localparam instr_t OP_DROP = 8'h11;
  localparam instr_t OP_SWAP = 8'h12;
  localparam instr_t OP_JMP = 8'h20;
  localparam instr_t OP_CALL = 8'h21;
  localparam instr_t OP_RETURN = 8'h22;
  localparam instr_t OP_LOOP = 8'h23;
  localparam instr_t OP_BREAK = 8'h24;
  localparam instr_t OP_STOP = 8'h25;
  localparam instr_t OP_INDEX = 8'h30;
  localparam instr_t OP_SEND = 8'h31;
  localparam instr_t OP_SEF = 8'h32;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_ADDC, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
  } alu_op_e;

  // Pop two without a push is needed by LOOP and SEF
  typedef enum logic [2:0] {
    MOVE_NONE, MOVE_PUSH, MOVE_POP, MOVE_POP2, MOVE_POP2_PUSH, MOVE_SWAP
  } stack_move_e;

  typedef enum logic [1:0] {
    PUSH_IMM, PUSH_ALU, PUSH_TOP, PUSH_INDEX
  } push_src_e;

  typedef enum logic [2:0] {
    FLOW_ADVANCE, FLOW_JUMP, FLOW_CALL, FLOW_RETURN, FLOW_HOLD
  } flow_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic store_carry;
    stack_move_e stack_move;
    push_src_e push_src;
    logic [IMM_WIDTH-1:0] imm;
    flow_op_e flow_op;
    logic loop_start;
    logic loop_break;
    logic set_fault;
    logic send;
  } ctrl_t;

  typedef struct packed {
    pc_t beginning;
    pc_t ending;
    word_t total;
    word_t index;
  } loop_frame_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/10ps

module alu import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  alu_op_e op,
  input  logic    store_carry,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic carry;
  logic carry_out;
  logic [WORD_WIDTH:0] wide;

  // The extra top bit of the wide result is the carry, or the borrow for a subtract
  always_comb begin
    wide = '0;
    case (op)
      ALU_ADD:  wide = {1'b0, a} + {1'b0, b};
      ALU_ADDC: wide = {1'b0, a} + {1'b0, b} + {{WORD_WIDTH{1'b0}}, carry};
      ALU_SUB:  wide = {1'b0, a} - {1'b0, b};
      ALU_AND:  wide = {1'b0, a & b};
      ALU_OR:   wide = {1'b0, a | b};
      ALU_XOR:  wide = {1'b0, a ^ b};
      default:  wide = '0;
    endcase
  end

  assign result = wide[WORD_WIDTH-1:0];
  assign carry_out = wide[WORD_WIDTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      carry <= 1'b0;
    end else if (store_carry) begin
      carry <= carry_out;
    end
  end

endmodule

// ==== lifo_stack.sv ====
`timescale 1ns/10ps

module lifo_stack import core_pkg::*; #(
  parameter type entry_t = logic,
  parameter int  DEPTH = 2
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  logic   pop,
  input  entry_t insert,
  output entry_t top,
  output logic   empty
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t entries [DEPTH];
  logic [CNT_W-1:0] count;
  logic [IDX_W-1:0] top_idx;

  assign top_idx = IDX_W'(count - CNT_W'(1));
  assign top = entries[top_idx];
  assign empty = (count == '0);

  // A push onto a full stack is dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (push && count < CNT_W'(DEPTH)) begin
      count <= count + CNT_W'(1);
    end else if (pop && !empty) begin
      count <= count - CNT_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push && count < CNT_W'(DEPTH)) begin
      entries[IDX_W'(count)] <= insert;
    end
  end

endmodule

// ==== data_stack.sv ====
`timescale 1ns/10ps

module data_stack import core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  ctrl_t ctrl,
  input  word_t alu_result,
  input  word_t loop_index,
  output word_t alu_a,
  output word_t alu_b,
  output word_t top,
  output word_t second,
  output logic  fault_valid,
  output logic  [$clog2(FAULT_COUNT)-1:0] fault_id
);

  // Top and second live in registers, the rest of the stack in the array below them
  localparam int BELOW = DSTACK_DEPTH - 2;
  localparam int CNT_W = $clog2(DSTACK_DEPTH + 1);
  localparam int IDX_W = $clog2(BELOW);

  word_t below [BELOW];
  logic [CNT_W-1:0] depth;
  logic [CNT_W-1:0] need;
  logic [IDX_W-1:0] third_idx;
  logic [IDX_W-1:0] fourth_idx;
  logic [IDX_W-1:0] spill_idx;
  logic pushing;
  logic overflow;
  logic underflow;
  word_t push_val;

  assign third_idx = IDX_W'(depth - CNT_W'(3));
  assign fourth_idx = IDX_W'(depth - CNT_W'(4));
  assign spill_idx = IDX_W'(depth - CNT_W'(2));

  always_comb begin
    case (ctrl.push_src)
      PUSH_IMM:   push_val = word_t'(ctrl.imm);
      PUSH_ALU:   push_val = alu_result;
      PUSH_TOP:   push_val = top;
      default:    push_val = loop_index;
    endcase
  end

  // Entries an instruction must find on the stack before it may move it
  always_comb begin
    case (ctrl.stack_move)
      MOVE_PUSH:      need = (ctrl.push_src == PUSH_TOP) ? CNT_W'(1) : CNT_W'(0);
      MOVE_POP:       need = CNT_W'(1);
      MOVE_POP2,
      MOVE_POP2_PUSH,
      MOVE_SWAP:      need = CNT_W'(2);
      default:        need = CNT_W'(0);
    endcase
  end

  assign pushing = (ctrl.stack_move == MOVE_PUSH);
  assign overflow = pushing && depth == CNT_W'(DSTACK_DEPTH);
  assign underflow = depth < need;
  assign fault_valid = overflow || underflow;
  assign fault_id = underflow;

  assign alu_a = second;
  assign alu_b = top;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth <= '0;
    end else if (!fault_valid) begin
      case (ctrl.stack_move)
        MOVE_PUSH:      depth <= depth + CNT_W'(1);
        MOVE_POP,
        MOVE_POP2_PUSH: depth <= depth - CNT_W'(1);
        MOVE_POP2:      depth <= depth - CNT_W'(2);
        default:        depth <= depth;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!fault_valid) begin
      case (ctrl.stack_move)
        MOVE_PUSH: begin
          if (depth >= CNT_W'(2)) begin
            below[spill_idx] <= second;
          end
          second <= top;
          top <= push_val;
        end
        MOVE_POP: begin
          top <= second;
          second <= below[third_idx];
        end
        MOVE_POP2: begin
          top <= below[third_idx];
          second <= below[fourth_idx];
        end
        MOVE_POP2_PUSH: begin
          top <= push_val;
          second <= below[third_idx];
        end
        MOVE_SWAP: begin
          top <= second;
          second <= top;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode import core_pkg::*; (
  input  instr_t instr,
  output logic   top_valid_send,
  input  logic   send_ready,
  output ctrl_t  ctrl
);

  ctrl_t dec;

  always_comb begin
    dec = '0;
    dec.alu_op = ALU_ADD;
    dec.stack_move = MOVE_NONE;
    dec.push_src = PUSH_IMM;
    dec.imm = instr[IMM_WIDTH-1:0];
    dec.flow_op = FLOW_ADVANCE;
    if (instr[7]) begin
      dec.stack_move = MOVE_PUSH;
    end else begin
      case (instr)
        OP_ADD, OP_ADDC, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
          dec.stack_move = MOVE_POP2_PUSH;
          dec.push_src = PUSH_ALU;
          dec.store_carry = (instr == OP_ADD || instr == OP_ADDC || instr == OP_SUB);
          case (instr)
            OP_ADDC: dec.alu_op = ALU_ADDC;
            OP_SUB:  dec.alu_op = ALU_SUB;
            OP_AND:  dec.alu_op = ALU_AND;
            OP_OR:   dec.alu_op = ALU_OR;
            OP_XOR:  dec.alu_op = ALU_XOR;
            default: dec.alu_op = ALU_ADD;
          endcase
        end
        OP_DUP: begin
          dec.stack_move = MOVE_PUSH;
          dec.push_src = PUSH_TOP;
        end
        OP_DROP:   dec.stack_move = MOVE_POP;
        OP_SWAP:   dec.stack_move = MOVE_SWAP;
        OP_JMP: begin
          dec.stack_move = MOVE_POP;
          dec.flow_op = FLOW_JUMP;
        end
        OP_CALL: begin
          dec.stack_move = MOVE_POP;
          dec.flow_op = FLOW_CALL;
        end
        OP_RETURN: dec.flow_op = FLOW_RETURN;
        OP_LOOP: begin
          dec.stack_move = MOVE_POP2;
          dec.loop_start = 1'b1;
        end
        OP_BREAK:  dec.loop_break = 1'b1;
        OP_STOP:   dec.flow_op = FLOW_HOLD;
        OP_INDEX: begin
          dec.stack_move = MOVE_PUSH;
          dec.push_src = PUSH_INDEX;
        end
        OP_SEND: begin
          dec.stack_move = MOVE_POP;
          dec.send = 1'b1;
        end
        OP_SEF: begin
          dec.stack_move = MOVE_POP2;
          dec.set_fault = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign top_valid_send = dec.send;

  // A send waiting for ready turns into a plain hold so nothing else moves
  always_comb begin
    ctrl = dec;
    if (dec.send && !send_ready) begin
      ctrl = '0;
      ctrl.flow_op = FLOW_HOLD;
    end
  end

endmodule

// ==== loop_control.sv ====
`timescale 1ns/10ps

module loop_control import core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  ctrl_t ctrl,
  input  pc_t   pc,
  input  word_t top,
  input  word_t second,
  input  logic  fault_valid,
  output word_t loop_index,
  output logic  loop_next,
  output logic  loop_exit,
  output pc_t   loop_begin,
  output pc_t   loop_end
);

  loop_frame_t frame;
  loop_frame_t saved;
  loop_frame_t idle_frame;
  logic saved_empty;
  logic start;
  logic iter_end;
  logic last_iter;
  word_t index_next;

  // The idle frame ends at all ones so it never matches a real address
  assign idle_frame = '{beginning: '0, ending: '1, total: '0, index: '0};

  assign start = ctrl.loop_start && !fault_valid;
  assign index_next = frame.index + word_t'(1);
  assign last_iter = index_next >= frame.total;

  // Only an instruction that falls through normally can finish a pass of the body
  assign iter_end = ctrl.flow_op == FLOW_ADVANCE && !fault_valid && !ctrl.loop_start &&
                    (pc + pc_t'(1)) == frame.ending;

  assign loop_exit = ctrl.loop_break || (iter_end && last_iter);
  assign loop_next = iter_end && !last_iter;
  assign loop_begin = frame.beginning;
  assign loop_end = frame.ending;
  assign loop_index = frame.index;

  lifo_stack #(.entry_t(loop_frame_t), .DEPTH(LSTACK_DEPTH)) u_lstack (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (start),
    .pop    (loop_exit),
    .insert (frame),
    .top    (saved),
    .empty  (saved_empty)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame <= idle_frame;
    end else if (start) begin
      frame <= '{beginning: pc + pc_t'(1), ending: top[PC_WIDTH-1:0],
                 total: second, index: '0};
    end else if (loop_exit) begin
      frame <= saved_empty ? idle_frame : saved;
    end else if (loop_next) begin
      frame.index <= index_next;
    end
  end

endmodule

// ==== flow_control.sv ====
`timescale 1ns/10ps

module flow_control import core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  ctrl_t ctrl,
  input  word_t top,
  input  word_t second,
  input  logic  fault_valid,
  input  logic  [$clog2(FAULT_COUNT)-1:0] fault_id,
  input  logic  loop_next,
  input  logic  loop_exit,
  input  pc_t   loop_begin,
  input  pc_t   loop_end,
  output pc_t   pc,
  output pc_t   prog_addr
);

  localparam int FID_W = $clog2(FAULT_COUNT);

  pc_t handlers [FAULT_COUNT];
  pc_t pc_advance;
  pc_t pc_next;
  pc_t return_addr;
  logic call_push;
  logic call_pop;
  logic call_empty;

  assign pc_advance = pc + pc_t'(1);

  // A fault behaves like a call to its handler
  assign call_push = fault_valid || ctrl.flow_op == FLOW_CALL;
  assign call_pop = !fault_valid && ctrl.flow_op == FLOW_RETURN && !call_empty;

  lifo_stack #(.entry_t(pc_t), .DEPTH(CSTACK_DEPTH)) u_cstack (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (call_push),
    .pop    (call_pop),
    .insert (pc_advance),
    .top    (return_addr),
    .empty  (call_empty)
  );

  always_comb begin
    if (ctrl.flow_op == FLOW_HOLD) begin
      pc_next = pc;
    end else if (fault_valid) begin
      pc_next = handlers[fault_id];
    end else if (ctrl.flow_op == FLOW_RETURN) begin
      pc_next = return_addr;
    end else if (ctrl.flow_op == FLOW_JUMP || ctrl.flow_op == FLOW_CALL) begin
      pc_next = top[PC_WIDTH-1:0];
    end else if (loop_exit) begin
      pc_next = loop_end;
    end else if (loop_next) begin
      pc_next = loop_begin;
    end else begin
      pc_next = pc_advance;
    end
  end

  // Address 0 is fetched throughout reset so the first instruction is ready on release
  assign prog_addr = rst_n ? pc_next : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
      for (int i = 0; i < FAULT_COUNT; i++) begin
        handlers[i] <= '0;
      end
    end else begin
      pc <= pc_next;
      if (ctrl.set_fault && !fault_valid && top < word_t'(FAULT_COUNT)) begin
        handlers[top[FID_W-1:0]] <= second[PC_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== stack_core.sv ====
`timescale 1ns/10ps

module stack_core import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  output pc_t    prog_addr,
  input  instr_t prog_data,
  output logic   send_valid,
  output word_t  send_data,
  input  logic   send_ready
);

  ctrl_t ctrl;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t top;
  word_t second;
  word_t loop_index;
  logic fault_valid;
  logic [$clog2(FAULT_COUNT)-1:0] fault_id;
  logic loop_next;
  logic loop_exit;
  pc_t loop_begin;
  pc_t loop_end;
  pc_t pc;

  assign send_data = top;

  instr_decode u_decode (
    .instr          (prog_data),
    .top_valid_send (send_valid),
    .send_ready     (send_ready),
    .ctrl           (ctrl)
  );

  // A faulting instruction must not leave a carry behind
  alu u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (ctrl.alu_op),
    .store_carry (ctrl.store_carry && !fault_valid),
    .a           (alu_a),
    .b           (alu_b),
    .result      (alu_result)
  );

  data_stack u_dstack (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .alu_result  (alu_result),
    .loop_index  (loop_index),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .top         (top),
    .second      (second),
    .fault_valid (fault_valid),
    .fault_id    (fault_id)
  );

  loop_control u_loop (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .pc          (pc),
    .top         (top),
    .second      (second),
    .fault_valid (fault_valid),
    .loop_index  (loop_index),
    .loop_next   (loop_next),
    .loop_exit   (loop_exit),
    .loop_begin  (loop_begin),
    .loop_end    (loop_end)
  );

  flow_control u_flow (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .top         (top),
    .second      (second),
    .fault_valid (fault_valid),
    .fault_id    (fault_id),
    .loop_next   (loop_next),
    .loop_exit   (loop_exit),
    .loop_begin  (loop_begin),
    .loop_end    (loop_end),
    .pc          (pc),
    .prog_addr   (prog_addr)
  );

endmodule

// ==== send_checker.sv ====
`timescale 1ns/10ps

module send_checker import core_pkg::*; #(
  parameter int MAX_WORDS = 12
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  send_valid,
  input  logic  send_ready,
  input  word_t send_data,
  input  word_t expected [MAX_WORDS],
  input  int    expected_count,
  output int    seen,
  output int    mismatches
);

  // A word transfers on each rising edge where valid and ready are both high
  always @(posedge clk) begin
    if (!rst_n) begin
      seen <= 0;
      mismatches <= 0;
    end else if (send_valid && send_ready) begin
      if (seen >= expected_count) begin
        $display("Extra word %h was sent after all %0d expected words",
                 send_data, expected_count);
        mismatches <= mismatches + 1;
      end else if (send_data !== expected[seen]) begin
        $display("ERROR send_data word %0d: expected %h, actual %h",
                 seen, expected[seen], send_data);
        mismatches <= mismatches + 1;
      end
      seen <= seen + 1;
    end
  end

endmodule

// ==== stack_core_props.sv ====
`timescale 1ns/10ps

module stack_core_props import core_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  send_valid,
  input word_t send_data,
  input logic  send_ready
);

  int unsigned assert_errors = 0;

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !send_valid)
    else begin
      assert_errors++;
      $error("send_valid is high during reset");
    end

  // Every program starts with a push, so the first cycle out of reset offers no word
  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !send_valid)
    else begin
      assert_errors++;
      $error("send_valid is high on the first cycle after reset");
    end

  held_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      send_valid && !send_ready |=> send_valid && $stable(send_data))
    else begin
      assert_errors++;
      $error("send_data or send_valid changed while the word waited for ready");
    end

endmodule

bind stack_core stack_core_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .send_valid (send_valid),
  .send_data  (send_data),
  .send_ready (send_ready)
);

// ==== tb_stack_core.sv ====
`timescale 1ns/10ps

module tb_stack_core import core_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int PROG_LEN = 64;
  localparam int MAX_SENDS = 12;
  localparam int MEM_SIZE = 256;
  localparam int TIMEOUT = 2000;

  logic clk;
  logic rst_n;
  pc_t prog_addr;
  instr_t prog_data;
  logic send_valid;
  word_t send_data;
  logic send_ready;

  instr_t mem [MEM_SIZE];
  pc_t addr_q;
  logic use_random;
  integer seed;
  integer rand_word;

  // Each row holds a test name, back-pressure mode, program image and expected words
  string test_name [NUM_TESTS];
  logic random_ready [NUM_TESTS];
  instr_t code [NUM_TESTS][PROG_LEN];
  word_t expect_words [NUM_TESTS][MAX_SENDS];
  int expect_count [NUM_TESTS];
  int num_rows;

  word_t cur_expect [MAX_SENDS];
  int cur_count;
  int seen_count;
  int mismatch_count;
  int failed_tests;
  int word_errors;

  stack_core uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .send_valid (send_valid),
    .send_data  (send_data),
    .send_ready (send_ready)
  );

  send_checker #(.MAX_WORDS(MAX_SENDS)) u_check (
    .clk            (clk),
    .rst_n          (rst_n),
    .send_valid     (send_valid),
    .send_ready     (send_ready),
    .send_data      (send_data),
    .expected       (cur_expect),
    .expected_count (cur_count),
    .seen           (seen_count),
    .mismatches     (mismatch_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Registered program memory takes the address on the rising edge and shows
  // the byte on the falling edge, well before the next rising edge
  always @(posedge clk) begin
    addr_q <= prog_addr;
  end

  always @(negedge clk) begin
    prog_data <= mem[addr_q];
  end

  always @(negedge clk) begin
    if (use_random) begin
      rand_word = $random(seed);
      send_ready <= rand_word[0];
    end else begin
      send_ready <= 1'b1;
    end
  end

  function automatic instr_t imm_op(input int value);
    return {1'b1, value[IMM_WIDTH-1:0]};
  endfunction

  task automatic add_test(input string name, input logic rnd,
                          input instr_t prog [$], input word_t sends [$]);
    test_name[num_rows] = name;
    random_ready[num_rows] = rnd;
    for (int i = 0; i < PROG_LEN; i++) begin
      if (i < prog.size()) begin
        code[num_rows][i] = prog[i];
      end else begin
        code[num_rows][i] = OP_STOP;
      end
    end
    for (int i = 0; i < MAX_SENDS; i++) begin
      if (i < sends.size()) begin
        expect_words[num_rows][i] = sends[i];
      end else begin
        expect_words[num_rows][i] = '0;
      end
    end
    expect_count[num_rows] = sends.size();
    num_rows++;
  endtask

  task automatic run_test(input int t);
    int cycles;
    logic timed_out;
    cycles = 0;
    timed_out = 1'b0;
    @(negedge clk);
    rst_n = 1'b0;
    // The memory is only read on falling edges, so it is reloaded on a rising one
    @(posedge clk);
    use_random = random_ready[t];
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = (i < PROG_LEN) ? code[t][i] : OP_STOP;
    end
    cur_expect = expect_words[t];
    cur_count = expect_count[t];
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    while (seen_count < cur_count && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (seen_count < cur_count) begin
      $display("Test %0d timed out with %0d of %0d words received",
               t, seen_count, cur_count);
      timed_out = 1'b1;
    end
    // Run on to STOP so that any extra word still reaches the checker
    cycles = 0;
    while (prog_data !== OP_STOP && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (prog_data !== OP_STOP) begin
      $display("Test %0d never reached its STOP instruction", t);
      timed_out = 1'b1;
    end
    word_errors += mismatch_count;
    if (timed_out || mismatch_count != 0) begin
      failed_tests++;
      $display("Test %0d (%s): FAIL, %0d words seen, %0d wrong",
               t, test_name[t], seen_count, mismatch_count);
    end else begin
      $display("Test %0d (%s): ok, %0d words", t, test_name[t], seen_count);
    end
  endtask

  initial begin
    instr_t prog [$];
    word_t sends [$];
    int assert_count;
    rst_n = 1'b0;
    send_ready = 1'b0;
    prog_data = 8'h00;
    use_random = 1'b0;
    seed = 32'hfe23;
    num_rows = 0;
    failed_tests = 0;
    word_errors = 0;
    cur_count = 0;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = OP_STOP;
    end
    for (int i = 0; i < MAX_SENDS; i++) begin
      cur_expect[i] = '0;
    end

    // The borrow of 0 - 1 feeds the first ADDC, which clears the carry again,
    // so only the carry of all ones plus one can reach the second ADDC
    prog = '{imm_op(5), imm_op(3), OP_ADD, OP_SEND,
             imm_op(5), imm_op(3), OP_SUB, OP_SEND,
             imm_op(12), imm_op(10), OP_AND, OP_SEND,
             imm_op(12), imm_op(10), OP_OR, OP_SEND,
             imm_op(12), imm_op(10), OP_XOR, OP_SEND,
             imm_op(7), OP_DUP, OP_ADD, OP_SEND,
             imm_op(1), imm_op(2), OP_SWAP, OP_SUB, OP_SEND,
             imm_op(9), imm_op(4), OP_DROP, OP_SEND,
             imm_op(0), imm_op(1), OP_SUB, OP_DUP, OP_SEND,
             imm_op(2), imm_op(3), OP_ADDC, OP_SEND,
             imm_op(1), OP_ADD, OP_SEND,
             imm_op(2), imm_op(3), OP_ADDC, OP_SEND,
             OP_STOP};
    sends = '{5 + 3, 5 - 3, 12 & 10, 12 | 10, 12 ^ 10, 7 + 7, 2 - 1, 9,
              32'hffff_ffff, 2 + 3 + 1, 0, 2 + 3 + 1};
    add_test("alu and stack", 1'b0, prog, sends);
    add_test("alu and stack, random ready", 1'b1, prog, sends);

    // The subroutine sits at 12 and the block at 6 is jumped over
    prog = '{imm_op(5), OP_SEND, imm_op(12), OP_CALL,
             imm_op(9), OP_JMP, imm_op(99), OP_SEND,
             OP_STOP, imm_op(3), OP_SEND, OP_STOP,
             imm_op(1), OP_SEND, imm_op(2), OP_SEND,
             OP_RETURN};
    sends = '{5, 1, 2, 3};
    add_test("call, return and jump", 1'b0, prog, sends);

    // Simple loop ends at 5, the outer loop at 20 and the inner one at 16
    prog = '{imm_op(3), imm_op(5), OP_LOOP, OP_INDEX, OP_SEND,
             imm_op(2), imm_op(20), OP_LOOP,
             imm_op(3), imm_op(16), OP_LOOP,
             OP_INDEX, OP_SEND, OP_BREAK, imm_op(99), OP_SEND,
             OP_INDEX, imm_op(10), OP_ADD, OP_SEND,
             OP_STOP};
    sends = '{0, 1, 2, 0, 10, 0, 11};
    add_test("loops and break", 1'b0, prog, sends);
    add_test("loops and break, random ready", 1'b1, prog, sends);

    // Handler 1 sits at 7, the ADD at 4 underflows and returns to 5
    prog = '{imm_op(7), imm_op(1), OP_SEF, imm_op(9), OP_ADD,
             OP_SEND, OP_STOP, imm_op(42), OP_SEND, OP_RETURN};
    sends = '{42, 9};
    add_test("underflow handler", 1'b0, prog, sends);

    for (int t = 0; t < num_rows; t++) begin
      run_test(t);
    end

    assert_count = uut.u_props.assert_errors;
    if (assert_count != 0) begin
      $display("The bound send properties failed %0d times", assert_count);
    end
    $display("Tests %0d, failed %0d, wrong words %0d, assertion failures %0d",
             num_rows, failed_tests, word_errors, assert_count);
    if (failed_tests == 0 && word_errors == 0 && assert_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
core_pkg.sv
alu.sv
lifo_stack.sv
data_stack.sv
instr_decode.sv
loop_control.sv
flow_control.sv
stack_core.sv
send_checker.sv
stack_core_props.sv
tb_stack_core.sv
